// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// First instruction fetched after reset
`define CPU_RESET_PC 32'h0000_3000

// General purpose register file
`define CPU_REG_COUNT 32
`define CPU_REG_BITS 5

`endif

// File: verilog/isaPkg.sv
`include "cpu_settings.svh"

package isaPkg;

	//////////////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// Function field of SPECIAL
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	//////////////////////////////////////////////////
	// Two views of one instruction word
	typedef struct packed {
		opcodeE                   opcode;
		logic [`CPU_REG_BITS-1:0] rs;
		logic [`CPU_REG_BITS-1:0] rt;
		logic [`CPU_REG_BITS-1:0] rd;
		logic [4:0]               shamt;
		functE                    funct;
	} rFields;

	// J target is {rs, rt, imm} of this view
	typedef struct packed {
		opcodeE                   opcode;
		logic [`CPU_REG_BITS-1:0] rs;
		logic [`CPU_REG_BITS-1:0] rt;
		logic [15:0]              imm;
	} iFields;

	typedef union packed {
		rFields rView;
		iFields iView;
	} instrWord;

endpackage

// File: verilog/ctrlPkg.sv
package ctrlPkg;

	// ALU function selected in decode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpE;

	// Source of the value written back
	typedef enum logic {
		wbAlu,
		wbMem
	} wbSelE;

	//////////////////////////////////////////////////
	// Operand source for forwarding
	typedef enum logic [1:0] {
		fwdReg,
		fwdFromM,
		fwdFromW
	} fwdSelE;

	// Same operand mux used by the branch compare and the ALU inputs
	function automatic logic [31:0] fwdPick(
		input fwdSelE sel,
		input logic [31:0] regVal,
		input logic [31:0] mVal,
		input logic [31:0] wVal
	);
		case (sel)
			fwdFromM: return mVal;
			fwdFromW: return wVal;
			default:  return regVal;
		endcase
	endfunction

endpackage

// File: verilog/fetchStage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetchStage (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic        takesBranch,
	input  logic [31:0] nextPc,
	output logic [31:0] pcF
);

	logic [31:0] pcSeq;

	// Fall-through address
	assign pcSeq = pcF + 32'd4;

	//////////////////////////////////////////////////
	// PC register
	// A redirect from decode lands after the delay slot has been fetched
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= `CPU_RESET_PC;
		end else if (!stall) begin
			pcF <= takesBranch ? nextPc : pcSeq;
		end
	end

	// Branch and jump targets from decode keep the PC on a word
	assert property (@(posedge clk) disable iff (!rstN)
		pcF[1:0] == 2'b00)
		else $error("pcF not word aligned: %h", pcF);

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decodeStage (
	input  logic              clk,
	input  logic              rstN,
	input  logic              stall,
	input  logic [31:0]       instrData,
	input  logic [31:0]       pcF,
	input  logic [4:0]        destW,
	input  logic [31:0]       resultW,
	input  logic              regWriteW,
	input  logic [31:0]       aluMFwd,
	input  ctrlPkg::fwdSelE   fwdBrA,
	input  ctrlPkg::fwdSelE   fwdBrB,
	output logic [4:0]        rsD,
	output logic [4:0]        rtD,
	output logic              isBranchD,
	output logic              readsRtD,
	output logic              takesBranch,
	output logic [31:0]       nextPc,
	output logic [4:0]        rsE,
	output logic [4:0]        rtE,
	output logic [4:0]        destE,
	output ctrlPkg::aluOpE    aluOpE,
	output logic              useImmE,
	output logic              memReadE,
	output logic              memWriteE,
	output logic              regWriteE,
	output logic [31:0]       opAE,
	output logic [31:0]       opBE,
	output logic [31:0]       immE
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrWord       instrD;
	logic [31:0]    pcD;
	logic [31:0]    pcDelay;
	logic [31:0]    regFile [`CPU_REG_COUNT];
	logic [31:0]    rdA;
	logic [31:0]    rdB;
	logic [31:0]    immD;
	logic [4:0]     destD;
	ctrlPkg::aluOpE aluOpD;
	logic           useImmD;
	logic           zeroExtD;
	logic           memReadD;
	logic           memWriteD;
	logic           regWriteD;
	logic           isJumpD;

	// Fetch/decode register frozen by a stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= '0;
			pcD <= '0;
		end else if (!stall) begin
			instrD <= instrData;
			pcD <= pcF;
		end
	end

	//////////////////////////////////////////////////
	// Control decode
	always_comb begin
		aluOpD = aluAdd;
		useImmD = 1'b0;
		zeroExtD = 1'b0;
		memReadD = 1'b0;
		memWriteD = 1'b0;
		regWriteD = 1'b0;
		destD = instrD.iView.rt;
		isBranchD = 1'b0;
		isJumpD = 1'b0;
		readsRtD = 1'b0;
		case (instrD.rView.opcode)
			opSpecial: begin
				destD = instrD.rView.rd;
				readsRtD = 1'b1;
				regWriteD = 1'b1;
				case (instrD.rView.funct)
					fnAddu: aluOpD = aluAdd;
					fnSubu: aluOpD = aluSub;
					fnAnd:  aluOpD = aluAnd;
					fnOr:   aluOpD = aluOr;
					fnSlt:  aluOpD = aluSlt;
					// nop and anything unsupported
					default: regWriteD = 1'b0;
				endcase
			end
			opAddiu: begin
				useImmD = 1'b1;
				regWriteD = 1'b1;
			end
			opOri: begin
				aluOpD = aluOr;
				useImmD = 1'b1;
				zeroExtD = 1'b1;
				regWriteD = 1'b1;
			end
			opLui: begin
				aluOpD = aluLui;
				useImmD = 1'b1;
				zeroExtD = 1'b1;
				regWriteD = 1'b1;
			end
			opLw: begin
				useImmD = 1'b1;
				memReadD = 1'b1;
				regWriteD = 1'b1;
			end
			opSw: begin
				useImmD = 1'b1;
				memWriteD = 1'b1;
				readsRtD = 1'b1;
			end
			opBeq: begin
				isBranchD = 1'b1;
				readsRtD = 1'b1;
			end
			opJ:     isJumpD = 1'b1;
			default: ;
		endcase
	end

	// j carries target bits in the rs field, so it reads no register
	assign rsD = isJumpD ? '0 : instrD.rView.rs;
	assign rtD = instrD.rView.rt;
	assign immD = zeroExtD ? {16'h0000, instrD.iView.imm} :
		{{16{instrD.iView.imm[15]}}, instrD.iView.imm};

	//////////////////////////////////////////////////
	// Register file
	// r0 is never written and always reads zero
	always_ff @(posedge clk) begin
		if (regWriteW && destW != '0) begin
			regFile[destW] <= resultW;
		end
	end

	// Write-through so a writeback in this cycle is seen here
	assign rdA = (rsD == '0) ? '0 :
		(regWriteW && destW == rsD) ? resultW : regFile[rsD];
	assign rdB = (rtD == '0) ? '0 :
		(regWriteW && destW == rtD) ? resultW : regFile[rtD];

	//////////////////////////////////////////////////
	// Branch resolution
	assign pcDelay = pcD + 32'd4;
	assign takesBranch = isJumpD || (isBranchD &&
		fwdPick(fwdBrA, rdA, aluMFwd, resultW) == fwdPick(fwdBrB, rdB, aluMFwd, resultW));
	assign nextPc = isJumpD ?
		{pcDelay[31:28], instrD.iView.rs, instrD.iView.rt, instrD.iView.imm, 2'b00} :
		pcDelay + {immD[29:0], 2'b00};

	// Decode/execute register loads a bubble on stall
	always_ff @(posedge clk) begin
		if (!rstN || stall) begin
			rsE <= '0;
			rtE <= '0;
			destE <= '0;
			memReadE <= 1'b0;
			memWriteE <= 1'b0;
			regWriteE <= 1'b0;
		end else begin
			rsE <= rsD;
			rtE <= rtD;
			destE <= destD;
			memReadE <= memReadD;
			memWriteE <= memWriteD;
			regWriteE <= regWriteD && destD != '0;
		end
	end

	always_ff @(posedge clk) begin
		aluOpE <= aluOpD;
		useImmE <= useImmD;
		opAE <= rdA;
		opBE <= rdB;
		immE <= immD;
	end

	// A write arriving from writeback never targets r0
	assert property (@(posedge clk) disable iff (!rstN)
		regWriteW |-> destW != '0)
		else $error("r0 reported as write destination");

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input  logic            clk,
	input  logic            rstN,
	input  logic [4:0]      rsE,
	input  logic [4:0]      rtE,
	input  logic [4:0]      destE,
	input  ctrlPkg::aluOpE  aluOpE,
	input  logic            useImmE,
	input  logic            memReadE,
	input  logic            memWriteE,
	input  logic            regWriteE,
	input  logic [31:0]     opAE,
	input  logic [31:0]     opBE,
	input  logic [31:0]     immE,
	input  ctrlPkg::fwdSelE fwdA,
	input  ctrlPkg::fwdSelE fwdB,
	input  logic [31:0]     resultW,
	output logic [31:0]     aluM,
	output logic [31:0]     storeDataM,
	output logic [4:0]      destM,
	output logic            memReadM,
	output logic            memWriteM,
	output logic            regWriteM
);
	import ctrlPkg::*;

	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluB;
	logic [31:0] aluE;

	//////////////////////////////////////////////////
	// Operand forwarding
	assign srcA = fwdPick(fwdA, opAE, aluM, resultW);
	assign srcB = fwdPick(fwdB, opBE, aluM, resultW);
	assign aluB = useImmE ? immE : srcB;

	// ALU, all arithmetic wraps
	always_comb begin
		case (aluOpE)
			aluSub:  aluE = srcA - aluB;
			aluAnd:  aluE = srcA & aluB;
			aluOr:   aluE = srcA | aluB;
			aluSlt:  aluE = {31'b0, $signed(srcA) < $signed(aluB)};
			aluLui:  aluE = {aluB[15:0], 16'h0000};
			default: aluE = srcA + aluB;
		endcase
	end

	//////////////////////////////////////////////////
	// Execute/memory register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			destM <= '0;
			memReadM <= 1'b0;
			memWriteM <= 1'b0;
			regWriteM <= 1'b0;
		end else begin
			destM <= destE;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
			regWriteM <= regWriteE;
		end
	end

	// sw data is rt after forwarding
	always_ff @(posedge clk) begin
		aluM <= aluE;
		storeDataM <= srcB;
	end

	// Hazard unit must only pick M for a matching ALU result
	assert property (@(posedge clk) disable iff (!rstN)
		fwdA == fwdFromM |-> destM == rsE && !memReadM)
		else $error("bad M forward on rs, rsE=%0d destM=%0d", rsE, destM);
	assert property (@(posedge clk) disable iff (!rstN)
		fwdB == fwdFromM |-> destM == rtE && !memReadM)
		else $error("bad M forward on rt, rtE=%0d destM=%0d", rtE, destM);

endmodule

// File: verilog/resultStage.sv
`timescale 1ns/10ps

module resultStage (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] aluM,
	input  logic [31:0] storeDataM,
	input  logic [4:0]  destM,
	input  logic        memReadM,
	input  logic        memWriteM,
	input  logic        regWriteM,
	input  logic [31:0] PrRD,
	output logic [31:2] PrAddr,
	output logic [31:0] PrWD,
	output logic        PrWE,
	output logic [4:0]  destW,
	output logic [31:0] resultW,
	output logic        regWriteW
);
	import ctrlPkg::*;

	wbSelE       wbSelM;
	logic [31:0] wbValueM;

	//////////////////////////////////////////////////
	// Processor bus, word addressed
	assign PrAddr = aluM[31:2];
	assign PrWD = storeDataM;
	assign PrWE = memWriteM;

	// Load data comes back in the same cycle
	assign wbSelM = memReadM ? wbMem : wbAlu;
	assign wbValueM = (wbSelM == wbMem) ? PrRD : aluM;

	// Memory/writeback register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			destW <= '0;
			regWriteW <= 1'b0;
		end else begin
			destW <= destM;
			regWriteW <= regWriteM;
		end
	end

	always_ff @(posedge clk) begin
		resultW <= wbValueM;
	end

	assert property (@(posedge clk) disable iff (!rstN) !(PrWE && memReadM))
		else $error("load and store both active in memory stage");
	assert property (@(posedge clk) disable iff (!rstN) PrWE |-> !$isunknown(PrAddr))
		else $error("store with unknown PrAddr");

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input  logic            clk,
	input  logic            rstN,
	input  logic [4:0]      rsD,
	input  logic [4:0]      rtD,
	input  logic [4:0]      rsE,
	input  logic [4:0]      rtE,
	input  logic [4:0]      destE,
	input  logic [4:0]      destM,
	input  logic [4:0]      destW,
	input  logic            memReadE,
	input  logic            memReadM,
	input  logic            regWriteE,
	input  logic            regWriteM,
	input  logic            regWriteW,
	input  logic            isBranchD,
	input  logic            readsRtD,
	output logic            stall,
	output ctrlPkg::fwdSelE fwdBrA,
	output ctrlPkg::fwdSelE fwdBrB,
	output ctrlPkg::fwdSelE fwdA,
	output ctrlPkg::fwdSelE fwdB
);
	import ctrlPkg::*;

	logic hitRsE;
	logic hitRtE;
	logic hitRsM;
	logic hitRtM;
	logic loadUse;
	logic branchWait;

	// Pending write to a source, r0 never counts
	function automatic logic pending(input logic wr, input logic [4:0] dest,
		input logic [4:0] src);
		return wr && dest != '0 && dest == src;
	endfunction

	// M only holds a usable value for ALU results
	function automatic fwdSelE pickSrc(input logic [4:0] src);
		if (pending(regWriteM && !memReadM, destM, src)) begin
			return fwdFromM;
		end
		if (pending(regWriteW, destW, src)) begin
			return fwdFromW;
		end
		return fwdReg;
	endfunction

	//////////////////////////////////////////////////
	// Stalls
	assign hitRsE = pending(regWriteE, destE, rsD);
	assign hitRtE = readsRtD && pending(regWriteE, destE, rtD);
	assign hitRsM = pending(regWriteM, destM, rsD);
	assign hitRtM = readsRtD && pending(regWriteM, destM, rtD);

	assign loadUse = memReadE && (hitRsE || hitRtE);
	// beq compares in decode, so a load still in M is not ready either
	assign branchWait = isBranchD && (hitRsE || hitRtE || (memReadM && (hitRsM || hitRtM)));
	assign stall = loadUse || branchWait;

	assign fwdBrA = pickSrc(rsD);
	assign fwdBrB = pickSrc(rtD);
	assign fwdA = pickSrc(rsE);
	assign fwdB = pickSrc(rtE);

	// Pipeline registers hold bubbles after one reset edge
	assert property (@(posedge clk) !rstN |=> (rstN || !stall))
		else $error("stall raised during reset");

endmodule

// File: verilog/cpuCore.sv
`timescale 1ns/10ps

module cpuCore (
	input  logic        clk,
	input  logic        rstN,
	output logic [31:0] instrAddr,
	input  logic [31:0] instrData,
	input  logic [31:0] PrRD,
	output logic [31:2] PrAddr,
	output logic [31:0] PrWD,
	output logic        PrWE
);
	import ctrlPkg::*;

	// Fetch and decode
	logic [31:0] pcF;
	logic [31:0] nextPc;
	logic takesBranch;
	logic stall;
	logic [4:0] rsD;
	logic [4:0] rtD;
	logic isBranchD;
	logic readsRtD;

	//////////////////////////////////////////////////
	// Execute stage inputs
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] destE;
	ctrlPkg::aluOpE aluOpE;
	logic useImmE;
	logic memReadE;
	logic memWriteE;
	logic regWriteE;
	logic [31:0] opAE;
	logic [31:0] opBE;
	logic [31:0] immE;
	fwdSelE fwdBrA;
	fwdSelE fwdBrB;
	fwdSelE fwdA;
	fwdSelE fwdB;

	// Memory and writeback
	logic [31:0] aluM;
	logic [31:0] storeDataM;
	logic [4:0] destM;
	logic memReadM;
	logic memWriteM;
	logic regWriteM;
	logic [4:0] destW;
	logic [31:0] resultW;
	logic regWriteW;

	assign instrAddr = pcF;

	fetchStage fetchStage_i (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.takesBranch(takesBranch),
		.nextPc(nextPc),
		.pcF(pcF)
	);

	decodeStage decodeStage_i (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.instrData(instrData),
		.pcF(pcF),
		.destW(destW),
		.resultW(resultW),
		.regWriteW(regWriteW),
		.aluMFwd(aluM),
		.fwdBrA(fwdBrA),
		.fwdBrB(fwdBrB),
		.rsD(rsD),
		.rtD(rtD),
		.isBranchD(isBranchD),
		.readsRtD(readsRtD),
		.takesBranch(takesBranch),
		.nextPc(nextPc),
		.rsE(rsE),
		.rtE(rtE),
		.destE(destE),
		.aluOpE(aluOpE),
		.useImmE(useImmE),
		.memReadE(memReadE),
		.memWriteE(memWriteE),
		.regWriteE(regWriteE),
		.opAE(opAE),
		.opBE(opBE),
		.immE(immE)
	);

	executeStage executeStage_i (
		.clk(clk),
		.rstN(rstN),
		.rsE(rsE),
		.rtE(rtE),
		.destE(destE),
		.aluOpE(aluOpE),
		.useImmE(useImmE),
		.memReadE(memReadE),
		.memWriteE(memWriteE),
		.regWriteE(regWriteE),
		.opAE(opAE),
		.opBE(opBE),
		.immE(immE),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.resultW(resultW),
		.aluM(aluM),
		.storeDataM(storeDataM),
		.destM(destM),
		.memReadM(memReadM),
		.memWriteM(memWriteM),
		.regWriteM(regWriteM)
	);

	resultStage resultStage_i (
		.clk(clk),
		.rstN(rstN),
		.aluM(aluM),
		.storeDataM(storeDataM),
		.destM(destM),
		.memReadM(memReadM),
		.memWriteM(memWriteM),
		.regWriteM(regWriteM),
		.PrRD(PrRD),
		.PrAddr(PrAddr),
		.PrWD(PrWD),
		.PrWE(PrWE),
		.destW(destW),
		.resultW(resultW),
		.regWriteW(regWriteW)
	);

	hazardUnit hazardUnit_i (
		.clk(clk),
		.rstN(rstN),
		.rsD(rsD),
		.rtD(rtD),
		.rsE(rsE),
		.rtE(rtE),
		.destE(destE),
		.destM(destM),
		.destW(destW),
		.memReadE(memReadE),
		.memReadM(memReadM),
		.regWriteE(regWriteE),
		.regWriteM(regWriteM),
		.regWriteW(regWriteW),
		.isBranchD(isBranchD),
		.readsRtD(readsRtD),
		.stall(stall),
		.fwdBrA(fwdBrA),
		.fwdBrB(fwdBrB),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

endmodule

// File: verif/cpuCore_tb.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuCore_tb;
	import isaPkg::*;

	localparam int PROG_DEPTH = 256;
	localparam int DATA_WORDS = 64;
	localparam int MAX_PROG = 96;
	localparam int RANDOM_PROGS = 40;
	localparam int RANDOM_LEN = 24;
	localparam int TEST_COUNT = RANDOM_PROGS + 4;
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 10;
	// Worst case four cycles per instruction plus reset, drain and slack
	localparam int WATCHDOG_NS = TEST_COUNT * (MAX_PROG * 4 + 40) * 20 + 2000;

	logic clk = 1'b0;
	logic rstN;
	logic [31:0] instrAddr;
	logic [31:0] instrData;
	logic [31:0] PrRD;
	logic [31:2] PrAddr;
	logic [31:0] PrWD;
	logic PrWE;

	logic [31:0] progMem [PROG_DEPTH];
	logic [31:0] dataMem [DATA_WORDS];
	logic [31:0] fetchOffset;
	int progLen;

	// Expected stores in program order
	logic [29:0] expAddr [$];
	logic [31:0] expData [$];
	int storeIdx = 0;
	int errCount = 0;
	int missCount;
	int testsRun;
	int testsFailed;
	integer seed = 32'he825;

	always #10 clk = ~clk;

	cpuCore cpuCore_i (
		.clk(clk),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.PrRD(PrRD),
		.PrAddr(PrAddr),
		.PrWD(PrWD),
		.PrWE(PrWE)
	);

	//////////////////////////////////////////////////
	// Memory models

	// Anything outside the loaded program reads as nop
	assign fetchOffset = (instrAddr - `CPU_RESET_PC) >> 2;
	assign instrData = (fetchOffset < PROG_DEPTH) ? progMem[fetchOffset[7:0]] : 32'h0;
	assign PrRD = dataMem[PrAddr[7:2]];

	function automatic logic [31:0] fillWord(input int addr);
		return (addr * 32'h9E37_79B9) ^ 32'h6A09_E667;
	endfunction

	// Refilled while reset is held
	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < DATA_WORDS; i++) begin
				dataMem[i[5:0]] <= fillWord(i);
			end
		end else if (PrWE) begin
			dataMem[PrAddr[7:2]] <= PrWD;
		end
	end

	//////////////////////////////////////////////////
	// Instruction assembly
	function automatic logic [31:0] encodeR(input functE fn, input int rd, input int rs,
		input int rt);
		instrWord w;
		w.rView.opcode = opSpecial;
		w.rView.rs = rs[4:0];
		w.rView.rt = rt[4:0];
		w.rView.rd = rd[4:0];
		w.rView.shamt = '0;
		w.rView.funct = fn;
		return w;
	endfunction

	// rt is the destination, or the data of sw, or the second beq operand
	function automatic logic [31:0] encodeI(input opcodeE op, input int rt, input int rs,
		input int imm);
		instrWord w;
		w.iView.opcode = op;
		w.iView.rs = rs[4:0];
		w.iView.rt = rt[4:0];
		w.iView.imm = imm[15:0];
		return w;
	endfunction

	// Target given as a program word index
	function automatic logic [31:0] encodeJ(input int idx);
		instrWord w;
		logic [31:0] tgt;
		tgt = (`CPU_RESET_PC >> 2) + idx;
		w.iView.opcode = opJ;
		{w.iView.rs, w.iView.rt, w.iView.imm} = tgt[25:0];
		return w;
	endfunction

	task automatic emit(input logic [31:0] word);
		progMem[progLen[7:0]] = word;
		progLen++;
	endtask

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	//////////////////////////////////////////////////
	// ISA level model with one delay slot
	function automatic void predictStores(input int count);
		logic [31:0] regs [32];
		logic [31:0] mem [DATA_WORDS];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] newNpc;
		logic [31:0] slot;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] res;
		logic [4:0] dest;
		instrWord w;
		int steps;
		for (int k = 0; k < 32; k++) begin
			regs[k[4:0]] = '0;
		end
		for (int k = 0; k < DATA_WORDS; k++) begin
			mem[k[5:0]] = fillWord(k);
		end
		expAddr.delete();
		expData.delete();
		pc = `CPU_RESET_PC;
		npc = pc + 32'd4;
		steps = 0;
		while (steps < 4 * count) begin
			slot = (pc - `CPU_RESET_PC) >> 2;
			if (slot >= count) begin
				break;
			end
			w = progMem[slot[7:0]];
			a = regs[w.rView.rs];
			b = regs[w.rView.rt];
			simm = {{16{w.iView.imm[15]}}, w.iView.imm};
			addr = a + simm;
			newNpc = npc + 32'd4;
			dest = '0;
			res = '0;
			case (w.iView.opcode)
				opSpecial: begin
					dest = w.rView.rd;
					case (w.rView.funct)
						fnAddu: res = a + b;
						fnSubu: res = a - b;
						fnAnd:  res = a & b;
						fnOr:   res = a | b;
						fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: dest = '0;
					endcase
				end
				opAddiu: begin
					dest = w.iView.rt;
					res = a + simm;
				end
				opOri: begin
					dest = w.iView.rt;
					res = a | {16'h0000, w.iView.imm};
				end
				opLui: begin
					dest = w.iView.rt;
					res = {w.iView.imm, 16'h0000};
				end
				opLw: begin
					dest = w.iView.rt;
					res = mem[addr[7:2]];
				end
				opSw: begin
					mem[addr[7:2]] = b;
					expAddr.push_back(addr[31:2]);
					expData.push_back(b);
				end
				opBeq: begin
					if (a == b) begin
						newNpc = npc + (simm << 2);
					end
				end
				opJ: newNpc = {npc[31:28], w.iView.rs, w.iView.rt, w.iView.imm, 2'b00};
				default: ;
			endcase
			if (dest != '0) begin
				regs[dest] = res;
			end
			pc = npc;
			npc = newNpc;
			steps++;
		end
	endfunction

	//////////////////////////////////////////////////
	// Store compare sampled at the rising edge
	always @(posedge clk) begin
		if (!rstN) begin
			storeIdx = 0;
		end else if ($isunknown(PrWE)) begin
			$display("PrWE is unknown at %0t", $time);
			errCount++;
		end else if (PrWE) begin
			if (storeIdx >= expAddr.size()) begin
				$display("Unexpected extra store to word %h at %0t", PrAddr, $time);
				errCount++;
			end else begin
				if (PrAddr !== expAddr[storeIdx]) begin
					$display("** Error at %0t: PrAddr expected %h, actual %h",
						$time, expAddr[storeIdx], PrAddr);
					errCount++;
				end
				if (PrWD !== expData[storeIdx]) begin
					$display("** Error at %0t: PrWD expected %h, actual %h",
						$time, expData[storeIdx], PrWD);
					errCount++;
				end
				storeIdx = storeIdx + 1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, the tests did not finish", $time);
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequencing

	// Every program first gives r1 to r31 known values
	task automatic beginTest();
		@(negedge clk);
		rstN = 1'b0;
		for (int i = 0; i < PROG_DEPTH; i++) begin
			progMem[i[7:0]] = '0;
		end
		progLen = 0;
		for (int k = 1; k < 32; k++) begin
			emit(encodeI(opAddiu, k, 0, k * 32'h123));
		end
	endtask

	task automatic runTest(input string name);
		int errBefore;
		int missBefore;
		int cycles;
		int errs;
		errBefore = errCount;
		missBefore = missCount;
		predictStores(progLen);
		repeat (RESET_CYCLES) @(negedge clk);
		// Core state at the end of reset
		if (instrAddr !== `CPU_RESET_PC) begin
			$display("** Error at %0t: instrAddr expected %h, actual %h",
				$time, `CPU_RESET_PC, instrAddr);
			errCount++;
		end
		if (PrWE !== 1'b0) begin
			$display("** Error at %0t: PrWE expected 0, actual %b", $time, PrWE);
			errCount++;
		end
		rstN = 1'b1;
		cycles = 0;
		while (storeIdx < expAddr.size() && cycles < progLen * 4 + 20) begin
			@(negedge clk);
			cycles++;
		end
		if (storeIdx < expAddr.size()) begin
			$display("%0d of %0d expected stores never appeared by %0t",
				expAddr.size() - storeIdx, expAddr.size(), $time);
			missCount++;
		end
		// Catch stores that come after the last expected one
		repeat (DRAIN_CYCLES) @(negedge clk);
		errs = (errCount - errBefore) + (missCount - missBefore);
		testsRun++;
		if (errs != 0) begin
			testsFailed++;
		end
		$display("test %0d (%s): %0d stores, %s", testsRun, name, expAddr.size(),
			(errs == 0) ? "ok" : "failed");
	endtask

	task automatic buildFirstStore();
		emit(encodeI(opLui, 1, 0, 16'h1234));
		emit(encodeI(opOri, 1, 1, 16'h5678));
		emit(encodeI(opSw, 1, 0, 0));
		emit(encodeI(opOri, 2, 0, 16'hbeef));
		emit(encodeI(opSw, 2, 0, 4));
	endtask

	task automatic buildAluProgram();
		emit(encodeI(opAddiu, 1, 0, -1));
		emit(encodeI(opAddiu, 2, 0, 1));
		// Wraps to zero with r2 from M and r1 from W
		emit(encodeR(fnAddu, 3, 1, 2));
		emit(encodeI(opSw, 3, 0, 4));
		emit(encodeI(opLui, 4, 0, 16'h8000));
		emit(encodeR(fnSubu, 5, 4, 2));
		emit(encodeR(fnSubu, 6, 0, 2));
		emit(encodeI(opSw, 5, 0, 8));
		emit(encodeI(opSw, 6, 0, 12));
		// Signed compare where 0x80000000 is negative
		emit(encodeR(fnSlt, 7, 4, 2));
		emit(encodeR(fnSlt, 8, 2, 4));
		emit(encodeI(opSw, 7, 0, 16));
		emit(encodeI(opSw, 8, 0, 20));
		emit(encodeR(fnAnd, 9, 1, 5));
		emit(encodeR(fnOr, 10, 4, 2));
		emit(encodeI(opSw, 9, 0, 24));
		emit(encodeI(opSw, 10, 0, 28));
		emit(encodeR(fnAddu, 11, 10, 10));
		emit(encodeR(fnAddu, 11, 11, 10));
		emit(encodeI(opSw, 11, 0, 32));
	endtask

	task automatic buildLoadProgram();
		emit(encodeI(opLw, 1, 0, 4));
		emit(encodeR(fnAddu, 2, 1, 1));
		emit(encodeI(opSw, 2, 0, 40));
		emit(encodeI(opLw, 3, 0, 8));
		emit(encodeI(opSw, 3, 0, 44));
		// beq on a load still in execute
		emit(encodeI(opLw, 4, 0, 8));
		emit(encodeI(opBeq, 3, 4, 2));
		emit(encodeI(opSw, 4, 0, 48));
		emit(encodeI(opSw, 1, 0, 52));
		// beq on a load already in memory
		emit(encodeI(opLw, 5, 0, 8));
		emit(encodeI(opAddiu, 6, 0, 7));
		emit(encodeI(opBeq, 3, 5, 2));
		emit(encodeI(opSw, 6, 0, 56));
		emit(encodeI(opSw, 6, 0, 64));
		emit(encodeI(opLw, 7, 0, 8));
		emit(encodeI(opBeq, 5, 7, 2));
		emit(encodeI(opSw, 7, 0, 60));
		emit(encodeI(opSw, 0, 0, 64));
		emit(encodeI(opSw, 5, 0, 68));
	endtask

	task automatic buildBranchProgram();
		emit(encodeI(opAddiu, 1, 0, 5));
		emit(encodeI(opAddiu, 2, 0, 5));
		emit(encodeI(opBeq, 2, 1, 2));
		emit(encodeI(opSw, 1, 0, 72));
		emit(encodeI(opSw, 2, 0, 76));
		emit(encodeI(opAddiu, 3, 0, 9));
		emit(encodeI(opBeq, 1, 3, 2));
		emit(encodeI(opSw, 3, 0, 80));
		emit(encodeI(opSw, 1, 0, 84));
		emit(encodeJ(progLen + 3));
		emit(encodeI(opSw, 2, 0, 88));
		emit(encodeI(opSw, 3, 0, 92));
		emit(encodeI(opSw, 1, 0, 96));
	endtask

	// Eight registers keep dependences frequent
	task automatic emitRandom();
		int rd;
		int rs;
		int rt;
		int imm;
		rd = randBelow(8);
		rs = randBelow(8);
		rt = randBelow(8);
		imm = randBelow(65536);
		case (randBelow(10))
			0: emit(encodeR(fnAddu, rd, rs, rt));
			1: emit(encodeR(fnSubu, rd, rs, rt));
			2: emit(encodeR(fnAnd, rd, rs, rt));
			3: emit(encodeR(fnOr, rd, rs, rt));
			4: emit(encodeR(fnSlt, rd, rs, rt));
			5: emit(encodeI(opAddiu, rd, rs, imm));
			6: emit(encodeI(opOri, rd, rs, imm));
			7: emit(encodeI(opLui, rd, 0, imm));
			8: emit(encodeI(opLw, rd, 0, 4 * randBelow(DATA_WORDS)));
			default: emit(encodeI(opSw, rt, 0, 4 * randBelow(DATA_WORDS)));
		endcase
	endtask

	task automatic buildRandomProgram();
		for (int n = 0; n < RANDOM_LEN; n++) begin
			emitRandom();
		end
		for (int n = 0; n < 4; n++) begin
			emit(encodeI(opSw, randBelow(8), 0, 240 + 4 * n));
		end
	endtask

	initial begin
		rstN = 1'b0;
		progLen = 0;
		missCount = 0;
		testsRun = 0;
		testsFailed = 0;

		beginTest();
		buildFirstStore();
		runTest("reset and first store");
		beginTest();
		buildAluProgram();
		runTest("alu and forwarding");
		beginTest();
		buildLoadProgram();
		runTest("load use and branch on load");
		beginTest();
		buildBranchProgram();
		runTest("branch and jump delay slots");
		for (int n = 0; n < RANDOM_PROGS; n++) begin
			beginTest();
			buildRandomProgram();
			runTest($sformatf("random program %0d", n));
		end

		$display("%0d tests run, %0d failed, %0d check errors, %0d missing store reports",
			testsRun, testsFailed, errCount, missCount);
		if (testsFailed == 0 && errCount == 0 && missCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/hazardUnit.sv
verilog/cpuCore.sv
verif/cpuCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cpuCore_tb -o cpuCoreSim
./obj_dir/cpuCoreSim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
